// ==== flist.f ====
+incdir+include
hdl/proc_pkg.sv
hdl/fetch.sv
hdl/decode.sv
hdl/hazardCtl.sv
hdl/execute.sv
hdl/memory.sv
hdl/proc.sv
tests/proc_tb.sv

// ==== Bender.yml ====
package:
  name: proc

sources:
  - include_dirs:
      - include
    files:
      - hdl/proc_pkg.sv
      - hdl/fetch.sv
      - hdl/decode.sv
      - hdl/hazardCtl.sv
      - hdl/execute.sv
      - hdl/memory.sv
      - hdl/proc.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/proc_tb.sv

// ==== tests/proc_tb.sv ====
// Processor testbench
`timescale 1ns/1ps
`default_nettype none
`include "proc_cfg.svh"

module proc_tb import proc_pkg::*; ();

   localparam int MAX_CYCLES = 2000;
   localparam int MAX_STEPS = 1000;
   localparam int WR_W = REG_W + DATA_W;
   localparam int IMEM_AW = $clog2(`PROC_IMEM_DEPTH);
   localparam int DMEM_AW = $clog2(`PROC_DMEM_DEPTH);
   // No instruction uses this opcode
   localparam logic [4:0] UNDEF_OP = 5'b11111;

   logic     clk;
   logic     rstN;
   logic     start;
   loadCmd_t load;
   logic     halted;
   logic     err;
   wbObs_t   wbObs;

   logic [DATA_W-1:0] progMem [`PROC_IMEM_DEPTH];
   logic [DATA_W-1:0] refDmem [`PROC_DMEM_DEPTH];
   logic [DATA_W-1:0] refRegs [`PROC_NUM_REGS];
   logic [WR_W-1:0]   expWrites [$];
   int                progLen;
   int                errors;
   int                checks;
   int unsigned       seedInit;

   proc i_proc (
      .clk    (clk),
      .rstN   (rstN),
      .start  (start),
      .load   (load),
      .halted (halted),
      .err    (err),
      .wbObs  (wbObs)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [DATA_W-1:0] signExt5(logic [4:0] v);
      return {{(DATA_W-5){v[4]}}, v};
   endfunction

   function automatic logic [DATA_W-1:0] signExt8(logic [7:0] v);
      return {{(DATA_W-8){v[7]}}, v};
   endfunction

   function automatic logic [DATA_W-1:0] dataFill(int addr);
      return DATA_W'(addr * 40503) ^ 16'h3c5a;
   endfunction

   function automatic logic [DATA_W-1:0] encAlu(aluFn_e fn, logic [REG_W-1:0] rd,
                                                logic [REG_W-1:0] rs, logic [REG_W-1:0] rt);
      return {OP_ALU, rs, rt, rd, fn};
   endfunction

   // ST puts its data register in the rd slot
   function automatic logic [DATA_W-1:0] encImm(opcode_e op, logic [REG_W-1:0] rd,
                                                logic [REG_W-1:0] rs, logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic logic [DATA_W-1:0] encByte(opcode_e op, logic [REG_W-1:0] r,
                                                 logic [7:0] imm);
      return {op, r, imm};
   endfunction

   function automatic logic [DATA_W-1:0] encBare(opcode_e op);
      return {op, {(DATA_W-5){1'b0}}};
   endfunction

   function automatic void newProgram();
      progLen = 0;
   endfunction

   function automatic void emit(logic [DATA_W-1:0] word);
      progMem[progLen] = word;
      progLen++;
   endfunction

   function automatic void recordWrite(logic [REG_W-1:0] rd, logic [DATA_W-1:0] val);
      refRegs[rd] = val;
      expWrites.push_back({rd, val});
   endfunction

   // Instruction-set model, one instruction per step until HALT
   function automatic void runReference();
      instr_u            ins;
      logic [DATA_W-1:0] pc;
      logic [DATA_W-1:0] a;
      logic [DATA_W-1:0] b;
      logic [DATA_W-1:0] addr;
      int                steps;
      bit                done;
      pc = '0;
      steps = 0;
      done = 1'b0;
      while (!done && steps < MAX_STEPS) begin
         ins = progMem[pc[IMEM_AW-1:0]];
         a = refRegs[ins.rType.rs];
         b = refRegs[ins.rType.rt];
         pc = pc + 1'b1;
         steps++;
         case (ins.rType.opcode)
            OP_ALU: begin
               case (ins.rType.fn)
                  FN_ADD:  recordWrite(ins.rType.rd, a + b);
                  FN_SUB:  recordWrite(ins.rType.rd, a - b);
                  FN_AND:  recordWrite(ins.rType.rd, a & b);
                  default: recordWrite(ins.rType.rd, a ^ b);
               endcase
            end
            OP_ADDI: recordWrite(ins.iType.rd, a + signExt5(ins.iType.imm));
            OP_LD: begin
               addr = a + signExt5(ins.iType.imm);
               recordWrite(ins.iType.rd, refDmem[addr[DMEM_AW-1:0]]);
            end
            OP_ST: begin
               addr = a + signExt5(ins.iType.imm);
               refDmem[addr[DMEM_AW-1:0]] = refRegs[ins.iType.rd];
            end
            OP_LBI: recordWrite(ins.iType.rs, signExt8(ins[7:0]));
            OP_BEQZ: begin
               if (a == '0) begin
                  pc = pc + signExt8(ins[7:0]);
               end
            end
            OP_HALT: done = 1'b1;
            // NOP and undefined opcodes change nothing
            default: ;
         endcase
      end
      assert (done) else begin
         errors++;
         $display("reference model did not reach HALT within %0d steps", MAX_STEPS);
      end
   endfunction

   function automatic void expectBit(string name, logic got, logic want);
      checks++;
      assert (got === want) else begin
         errors++;
         $display("error %s: expected %h, got %h", name, want, got);
      end
   endfunction

   task automatic applyReset();
      int r;
      rstN = 1'b0;
      repeat (8) @(negedge clk);
      rstN = 1'b1;
      for (r = 0; r < `PROC_NUM_REGS; r++) begin
         refRegs[r] = '0;
      end
      expWrites.delete();
   endtask

   task automatic writePort(loadTgt_e tgt, int addr, logic [DATA_W-1:0] data);
      @(negedge clk);
      load.strobe = 1'b1;
      load.target = tgt;
      load.addr = DATA_W'(addr);
      load.data = data;
   endtask

   task automatic releasePort();
      @(negedge clk);
      load = '0;
   endtask

   task automatic fillDataMem();
      int a;
      for (a = 0; a < `PROC_DMEM_DEPTH; a++) begin
         writePort(LOAD_DMEM, a, dataFill(a));
         refDmem[a] = dataFill(a);
      end
      releasePort();
   endtask

   // Load, start, then wait for halted and an empty write list
   task automatic runProgram();
      int i;
      int cycles;
      runReference();
      for (i = 0; i < progLen; i++) begin
         writePort(LOAD_IMEM, i, progMem[i]);
      end
      releasePort();
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      cycles = 0;
      while (!halted && cycles < MAX_CYCLES) begin
         @(negedge clk);
         cycles++;
      end
      checks++;
      assert (halted) else begin
         errors++;
         $display("timeout: halted did not rise within %0d cycles", MAX_CYCLES);
      end
      checks++;
      assert (expWrites.size() == 0) else begin
         errors++;
         $display("%0d expected register writes missing at halt", expWrites.size());
      end
      expWrites.delete();
   endtask

   task automatic addRandomCode(int count, bit withMem);
      int               i;
      int               kind;
      logic [REG_W-1:0] rd;
      logic [REG_W-1:0] rs;
      logic [REG_W-1:0] rt;
      logic [REG_W-1:0] lastRd;
      logic [REG_W-1:0] prevRd;
      lastRd = '0;
      prevRd = '0;
      for (i = 0; i < count; i++) begin
         kind = $urandom % (withMem ? 8 : 6);
         rd = REG_W'($urandom);
         // Lean on the two newest results
         rs = ($urandom % 4 != 0) ? lastRd : REG_W'($urandom);
         rt = ($urandom % 2 != 0) ? prevRd : lastRd;
         case (kind)
            4: emit(encImm(OP_ADDI, rd, rs, 5'($urandom)));
            5: emit(encByte(OP_LBI, rd, 8'($urandom)));
            6: emit(encImm(OP_LD, rd, rs, 5'($urandom)));
            7: emit(encImm(OP_ST, rt, rs, 5'($urandom)));
            default: emit(encAlu(aluFn_e'(2'(kind)), rd, rs, rt));
         endcase
         if (kind != 7) begin
            prevRd = lastRd;
            lastRd = rd;
         end
      end
   endtask

   always @(posedge clk) begin : compareWrites
      logic [WR_W-1:0] want;
      if (rstN && wbObs.valid) begin
         checks++;
         assert (expWrites.size() > 0) else begin
            errors++;
            $display("unexpected register write to r%0d with data %h", wbObs.rd, wbObs.data);
         end
         if (expWrites.size() > 0) begin
            want = expWrites.pop_front();
            assert (wbObs.rd == want[WR_W-1:DATA_W]) else begin
               errors++;
               $display("error wbObs.rd: expected %h, got %h", want[WR_W-1:DATA_W], wbObs.rd);
            end
            assert (wbObs.data == want[DATA_W-1:0]) else begin
               errors++;
               $display("error wbObs.data: expected %h, got %h", want[DATA_W-1:0], wbObs.data);
            end
         end
      end
   end

   initial begin : mainFlow
      int i;
      seedInit = $urandom(32'h633fa64d);
      rstN = 1'b0;
      start = 1'b0;
      load = '0;
      errors = 0;
      checks = 0;
      progLen = 0;
      applyReset();
      fillDataMem();

      // Quiet after reset, nothing written before start
      for (i = 0; i < 10; i++) begin
         @(negedge clk);
         expectBit("halted", halted, 1'b0);
         expectBit("err", err, 1'b0);
         expectBit("wbObs.valid", wbObs.valid, 1'b0);
      end

      // Random ALU, ADDI and LBI chains
      newProgram();
      addRandomCode(40, 1'b0);
      emit(encBare(OP_HALT));
      runProgram();

      // Stores, loads and load-use dependents
      newProgram();
      emit(encByte(OP_LBI, 3'd1, 8'd10));
      emit(encByte(OP_LBI, 3'd2, 8'hfd));
      emit(encImm(OP_ST, 3'd2, 3'd1, 5'd0));
      emit(encAlu(FN_ADD, 3'd3, 3'd1, 3'd2));
      emit(encImm(OP_ST, 3'd3, 3'd1, 5'd1));
      emit(encImm(OP_LD, 3'd4, 3'd1, 5'd0));
      emit(encAlu(FN_ADD, 3'd5, 3'd4, 3'd1));
      emit(encImm(OP_LD, 3'd6, 3'd1, 5'd1));
      emit(encAlu(FN_SUB, 3'd7, 3'd1, 3'd6));
      emit(encImm(OP_LD, 3'd0, 3'd2, 5'h1e));
      emit(encAlu(FN_XOR, 3'd0, 3'd0, 3'd7));
      emit(encImm(OP_LD, 3'd4, 3'd1, 5'd1));
      emit(encImm(OP_ST, 3'd4, 3'd1, 5'd2));
      emit(encImm(OP_LD, 3'd5, 3'd1, 5'd2));
      emit(encImm(OP_LD, 3'd6, 3'd5, 5'd3));
      emit(encAlu(FN_AND, 3'd7, 3'd6, 3'd0));
      emit(encBare(OP_HALT));
      runProgram();

      // Branches right after their producers, taken and not taken
      newProgram();
      emit(encByte(OP_LBI, 3'd1, 8'd0));
      emit(encByte(OP_BEQZ, 3'd1, 8'd2));
      emit(encByte(OP_LBI, 3'd2, 8'd5));
      emit(encByte(OP_LBI, 3'd3, 8'd6));
      emit(encImm(OP_ADDI, 3'd4, 3'd1, 5'd3));
      emit(encByte(OP_BEQZ, 3'd4, 8'd1));
      emit(encByte(OP_LBI, 3'd5, 8'd7));
      emit(encAlu(FN_SUB, 3'd6, 3'd4, 3'd4));
      emit(encBare(OP_NOP));
      emit(encByte(OP_BEQZ, 3'd6, 8'd1));
      emit(encByte(OP_LBI, 3'd7, 8'd9));
      emit(encImm(OP_ST, 3'd6, 3'd1, 5'd4));
      emit(encImm(OP_LD, 3'd2, 3'd1, 5'd4));
      emit(encByte(OP_BEQZ, 3'd2, 8'd1));
      emit(encByte(OP_LBI, 3'd3, 8'd1));
      emit(encImm(OP_ADDI, 3'd3, 3'd2, 5'h1f));
      emit(encByte(OP_BEQZ, 3'd3, 8'hf0));
      emit(encBare(OP_HALT));
      runProgram();

      // Undefined opcode keeps err until reset
      newProgram();
      emit(encByte(OP_LBI, 3'd1, 8'd4));
      emit({UNDEF_OP, {(DATA_W-5){1'b0}}});
      emit(encImm(OP_ADDI, 3'd2, 3'd1, 5'd1));
      emit(encBare(OP_HALT));
      expectBit("err", err, 1'b0);
      runProgram();
      expectBit("err", err, 1'b1);
      repeat (5) @(negedge clk);
      expectBit("err", err, 1'b1);
      applyReset();
      expectBit("err", err, 1'b0);
      expectBit("halted", halted, 1'b0);

      // Fresh program after reset, then a reload while halted
      newProgram();
      addRandomCode(30, 1'b1);
      emit(encBare(OP_HALT));
      runProgram();
      newProgram();
      addRandomCode(30, 1'b1);
      emit(encBare(OP_HALT));
      runProgram();
      // Halted holds with no new start
      repeat (5) @(negedge clk);
      expectBit("halted", halted, 1'b1);

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== hdl/proc.sv ====
// Pipelined processor top
`timescale 1ns/1ps
`default_nettype none

module proc import proc_pkg::*; (
   input  logic     clk,
   input  logic     rstN,
   input  logic     start,
   input  loadCmd_t load,
   output logic     halted,
   output logic     err,
   output wbObs_t   wbObs
);

   ifId_t             ifId;
   idEx_t             idEx;
   exMem_t            exMem;
   memWb_t            memWb;
   logic              stall;
   logic              branchTaken;
   logic              wbHalt;
   logic              loadUseStall;
   logic [DATA_W-1:0] branchTarget;
   logic [DATA_W-1:0] wbVal;
   fwdSel_e           fwdA;
   fwdSel_e           fwdB;
   fwdSel_e           branchFwd;

   assign wbVal = wbData(memWb);
   assign wbHalt = memWb.valid && memWb.halt;

   fetch i_fetch (
      .clk          (clk),
      .rstN         (rstN),
      .start        (start),
      .load         (load),
      .stall        (stall),
      .branchTaken  (branchTaken),
      .branchTarget (branchTarget),
      .wbHalt       (wbHalt),
      .ifId         (ifId),
      .halted       (halted)
   );

   decode i_decode (
      .clk          (clk),
      .rstN         (rstN),
      .ifId         (ifId),
      .memWb        (memWb),
      .exFwdData    (exMem.aluOut),
      .branchFwd    (branchFwd),
      .stall        (stall),
      .idEx         (idEx),
      .branchTaken  (branchTaken),
      .branchTarget (branchTarget),
      .err          (err)
   );

   hazardCtl i_hazardCtl (
      .ifId      (ifId),
      .idEx      (idEx),
      .exMem     (exMem),
      .memWb     (memWb),
      .stall     (stall),
      .fwdA      (fwdA),
      .fwdB      (fwdB),
      .branchFwd (branchFwd)
   );

   execute i_execute (
      .clk        (clk),
      .rstN       (rstN),
      .idEx       (idEx),
      .fwdA       (fwdA),
      .fwdB       (fwdB),
      .memFwdData (exMem.aluOut),
      .wbFwdData  (wbVal),
      .exMem      (exMem)
   );

   memory i_memory (
      .clk   (clk),
      .rstN  (rstN),
      .exMem (exMem),
      .load  (load),
      .memWb (memWb)
   );

   assign wbObs.valid = memWb.valid && memWb.regWrite;
   assign wbObs.rd = memWb.rd;
   assign wbObs.data = wbVal;

   // The bubble behind a load-use stall must clear the hazard
   assign loadUseStall = stall && idEx.memRead;

   assert property (@(posedge clk) disable iff (!rstN) loadUseStall |=> !loadUseStall);

endmodule

`default_nettype wire

// ==== hdl/memory.sv ====
// Data memory stage
`timescale 1ns/1ps
`default_nettype none
`include "proc_cfg.svh"

module memory import proc_pkg::*; (
   input  logic     clk,
   input  logic     rstN,
   input  exMem_t   exMem,
   input  loadCmd_t load,
   output memWb_t   memWb
);

   localparam int DMEM_AW = $clog2(`PROC_DMEM_DEPTH);

   logic [DATA_W-1:0]  dmem [`PROC_DMEM_DEPTH];
   logic [DMEM_AW-1:0] addr;

   // Word addressed, wraps at the memory depth
   assign addr = exMem.aluOut[DMEM_AW-1:0];

   always_ff @(posedge clk) begin
      if (exMem.valid && exMem.memWrite) begin
         dmem[addr] <= exMem.storeData;
      end else if (load.strobe && load.target == LOAD_DMEM) begin
         dmem[load.addr[DMEM_AW-1:0]] <= load.data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         memWb.valid <= 1'b0;
      end else begin
         memWb.valid <= exMem.valid;
         memWb.rd <= exMem.rd;
         memWb.aluOut <= exMem.aluOut;
         memWb.memData <= dmem[addr];
         memWb.memToReg <= exMem.memRead;
         memWb.regWrite <= exMem.regWrite;
         memWb.halt <= exMem.halt;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/execute.sv ====
// Execute stage
`timescale 1ns/1ps
`default_nettype none

module execute import proc_pkg::*; (
   input  logic              clk,
   input  logic              rstN,
   input  idEx_t             idEx,
   input  fwdSel_e           fwdA,
   input  fwdSel_e           fwdB,
   input  logic [DATA_W-1:0] memFwdData,
   input  logic [DATA_W-1:0] wbFwdData,
   output exMem_t            exMem
);

   logic [DATA_W-1:0] opA;
   logic [DATA_W-1:0] opB;
   logic [DATA_W-1:0] immBase;
   logic [DATA_W-1:0] result;

   assign opA = pickOperand(fwdA, idEx.opA, memFwdData, wbFwdData);
   assign opB = pickOperand(fwdB, idEx.opB, memFwdData, wbFwdData);

   // LBI carries a non-ADD function and adds to zero
   assign immBase = (idEx.aluFn == FN_ADD) ? opA : '0;

   always_comb begin
      if (idEx.useImm) begin
         result = immBase + idEx.imm;
      end else begin
         case (idEx.aluFn)
            FN_ADD:  result = opA + opB;
            FN_SUB:  result = opA - opB;
            FN_AND:  result = opA & opB;
            default: result = opA ^ opB;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         exMem.valid <= 1'b0;
      end else begin
         exMem.valid <= idEx.valid;
         exMem.rd <= idEx.rd;
         exMem.aluOut <= result;
         exMem.storeData <= opB;
         exMem.memRead <= idEx.memRead;
         exMem.memWrite <= idEx.memWrite;
         exMem.regWrite <= idEx.regWrite;
         exMem.halt <= idEx.halt;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/hazardCtl.sv ====
// Pipeline hazard control
`timescale 1ns/1ps
`default_nettype none

module hazardCtl import proc_pkg::*; (
   input  ifId_t   ifId,
   input  idEx_t   idEx,
   input  exMem_t  exMem,
   input  memWb_t  memWb,
   output logic    stall,
   output fwdSel_e fwdA,
   output fwdSel_e fwdB,
   output fwdSel_e branchFwd
);

   instr_u           ins;
   logic [REG_W-1:0] srcA;
   logic [REG_W-1:0] srcB;
   logic             useA;
   logic             useB;
   logic             isBranch;
   logic             loadUse;
   logic             branchOnEx;
   logic             branchOnLoad;

   // Memory stage holds the newer value
   function automatic fwdSel_e fwdFor(logic [REG_W-1:0] src, exMem_t em, memWb_t mw);
      if (em.valid && em.regWrite && em.rd == src) begin
         return FWD_MEM;
      end else if (mw.valid && mw.regWrite && mw.rd == src) begin
         return FWD_WB;
      end
      return FWD_REG;
   endfunction

   assign ins = ifId.instr;
   assign srcA = ins.iType.rs;
   assign srcB = rtField(ins);
   assign useA = ifId.valid && readsRs(ins);
   assign useB = ifId.valid && readsRt(ins);
   assign isBranch = ifId.valid && (ins.rType.opcode == OP_BEQZ);

   assign loadUse = idEx.valid && idEx.memRead &&
                    ((useA && idEx.rd == srcA) || (useB && idEx.rd == srcB));

   // Branch operand is not ready yet
   assign branchOnEx = isBranch && idEx.valid && idEx.regWrite && idEx.rd == srcA;
   assign branchOnLoad = isBranch && exMem.valid && exMem.memRead && exMem.rd == srcA;

   assign stall = loadUse || branchOnEx || branchOnLoad;

   always_comb begin
      fwdA = fwdFor(idEx.rs, exMem, memWb);
      fwdB = fwdFor(idEx.rt, exMem, memWb);
      branchFwd = fwdFor(srcA, exMem, memWb);
   end

endmodule

`default_nettype wire

// ==== hdl/decode.sv ====
// Instruction decode stage
`timescale 1ns/1ps
`default_nettype none
`include "proc_cfg.svh"

module decode import proc_pkg::*; (
   input  logic              clk,
   input  logic              rstN,
   input  ifId_t             ifId,
   input  memWb_t            memWb,
   input  logic [DATA_W-1:0] exFwdData,
   input  fwdSel_e           branchFwd,
   input  logic              stall,
   output idEx_t             idEx,
   output logic              branchTaken,
   output logic [DATA_W-1:0] branchTarget,
   output logic              err
);

   instr_u            ins;
   logic [DATA_W-1:0] regs [`PROC_NUM_REGS];
   logic [DATA_W-1:0] wbVal;
   logic [DATA_W-1:0] rdA;
   logic [DATA_W-1:0] rdB;
   logic [DATA_W-1:0] brOperand;
   logic [DATA_W-1:0] imm;
   logic [DATA_W-1:0] imm8;
   logic [REG_W-1:0]  rsIdx;
   logic [REG_W-1:0]  rtIdx;
   logic [REG_W-1:0]  rdIdx;
   logic              wbEn;
   logic              legal;
   logic              isBranch;
   logic              regWrite;
   logic              useImm;
   logic              memRead;
   logic              memWrite;
   logic              halt;
   aluFn_e            fn;

   assign ins = ifId.instr;
   assign rsIdx = ins.iType.rs;
   assign rtIdx = rtField(ins);
   assign wbVal = wbData(memWb);
   assign wbEn = memWb.valid && memWb.regWrite;

   // Write-through so a same-cycle write is seen
   assign rdA = (wbEn && memWb.rd == rsIdx) ? wbVal : regs[rsIdx];
   assign rdB = (wbEn && memWb.rd == rtIdx) ? wbVal : regs[rtIdx];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         regs <= '{default: '0};
      end else if (wbEn) begin
         regs[memWb.rd] <= wbVal;
      end
   end

   assign imm8 = {{(DATA_W-8){ins.iType.rd[REG_W-1]}}, ins.iType.rd, ins.iType.imm};

   always_comb begin
      legal = 1'b1;
      isBranch = 1'b0;
      regWrite = 1'b0;
      useImm = 1'b0;
      memRead = 1'b0;
      memWrite = 1'b0;
      halt = 1'b0;
      fn = FN_ADD;
      rdIdx = ins.iType.rd;
      imm = {{(DATA_W-5){ins.iType.imm[4]}}, ins.iType.imm};
      case (ins.rType.opcode)
         OP_ALU: begin
            regWrite = 1'b1;
            fn = ins.rType.fn;
            rdIdx = ins.rType.rd;
         end
         OP_ADDI: begin
            regWrite = 1'b1;
            useImm = 1'b1;
         end
         OP_LD: begin
            regWrite = 1'b1;
            useImm = 1'b1;
            memRead = 1'b1;
         end
         OP_ST: begin
            useImm = 1'b1;
            memWrite = 1'b1;
         end
         OP_LBI: begin
            // Any function other than ADD drops the base register
            regWrite = 1'b1;
            useImm = 1'b1;
            fn = FN_XOR;
            rdIdx = rsIdx;
            imm = imm8;
         end
         OP_BEQZ: isBranch = 1'b1;
         OP_HALT: halt = 1'b1;
         OP_NOP: ;
         default: legal = 1'b0;
      endcase
   end

   assign brOperand = pickOperand(branchFwd, rdA, exFwdData, wbVal);
   assign branchTaken = ifId.valid && isBranch && !stall && (brOperand == '0);
   assign branchTarget = ifId.pcInc + imm8;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         err <= 1'b0;
      end else if (ifId.valid && !legal) begin
         err <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         idEx.valid <= 1'b0;
      end else begin
         idEx.valid <= ifId.valid && !stall && !branchTaken;
         idEx.rs <= rsIdx;
         idEx.rt <= rtIdx;
         idEx.rd <= rdIdx;
         idEx.opA <= rdA;
         idEx.opB <= rdB;
         idEx.imm <= imm;
         idEx.aluFn <= fn;
         idEx.useImm <= useImm;
         idEx.memRead <= memRead;
         idEx.memWrite <= memWrite;
         idEx.regWrite <= regWrite;
         idEx.halt <= halt;
      end
   end

   // Fetch squashes the slot behind a taken branch
   assert property (@(posedge clk) disable iff (!rstN)
      branchTaken |=> !ifId.valid);

endmodule

`default_nettype wire

// ==== hdl/fetch.sv ====
// Instruction fetch stage
`timescale 1ns/1ps
`default_nettype none
`include "proc_cfg.svh"

module fetch import proc_pkg::*; (
   input  logic              clk,
   input  logic              rstN,
   input  logic              start,
   input  loadCmd_t          load,
   input  logic              stall,
   input  logic              branchTaken,
   input  logic [DATA_W-1:0] branchTarget,
   input  logic              wbHalt,
   output ifId_t             ifId,
   output logic              halted
);

   localparam int IMEM_AW = $clog2(`PROC_IMEM_DEPTH);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_RUNNING,
      ST_HALTED
   } runState_e;

   runState_e         state;
   logic [DATA_W-1:0] imem [`PROC_IMEM_DEPTH];
   logic [DATA_W-1:0] pc;
   logic [DATA_W-1:0] pcInc;
   logic              haltSeen;
   logic              haltDecoded;

   assign pcInc = pc + 1'b1;
   assign haltDecoded = ifId.valid && (ifId.instr.rType.opcode == OP_HALT);
   assign halted = (state == ST_HALTED) || wbHalt;

   always_ff @(posedge clk) begin
      if (load.strobe && load.target == LOAD_IMEM) begin
         imem[load.addr[IMEM_AW-1:0]] <= load.data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= ST_IDLE;
         pc <= '0;
         haltSeen <= 1'b0;
         ifId.valid <= 1'b0;
      end else begin
         case (state)
            ST_RUNNING: begin
               if (wbHalt) begin
                  state <= ST_HALTED;
                  ifId.valid <= 1'b0;
               end else if (!stall) begin
                  if (branchTaken) begin
                     // Drop the word behind the branch
                     pc <= branchTarget;
                     ifId.valid <= 1'b0;
                  end else if (haltDecoded) begin
                     haltSeen <= 1'b1;
                     ifId.valid <= 1'b0;
                  end else if (!haltSeen) begin
                     ifId.valid <= 1'b1;
                     ifId.pc <= pc;
                     ifId.pcInc <= pcInc;
                     ifId.instr <= imem[pc[IMEM_AW-1:0]];
                     pc <= pcInc;
                  end else begin
                     ifId.valid <= 1'b0;
                  end
               end
            end
            default: begin
               ifId.valid <= 1'b0;
               if (start) begin
                  state <= ST_RUNNING;
                  pc <= '0;
                  haltSeen <= 1'b0;
               end
            end
         endcase
      end
   end

   // Program image only changes while the core is stopped
   assert property (@(posedge clk) disable iff (!rstN)
      (load.strobe && load.target == LOAD_IMEM) |-> state != ST_RUNNING);

endmodule

`default_nettype wire

// ==== hdl/proc_pkg.sv ====
// Processor shared types
`default_nettype none
`include "proc_cfg.svh"

package proc_pkg;

   localparam int DATA_W = `PROC_DATA_W;
   localparam int REG_W = $clog2(`PROC_NUM_REGS);

   typedef enum logic [4:0] {
      OP_HALT = 5'b00000,
      OP_NOP  = 5'b00001,
      OP_ADDI = 5'b01000,
      OP_BEQZ = 5'b01100,
      OP_ST   = 5'b10000,
      OP_LD   = 5'b10001,
      OP_LBI  = 5'b11000,
      OP_ALU  = 5'b11011
   } opcode_e;

   typedef enum logic [1:0] {
      FN_ADD = 2'b00,
      FN_SUB = 2'b01,
      FN_XOR = 2'b10,
      FN_AND = 2'b11
   } aluFn_e;

   typedef enum logic [1:0] {
      FWD_REG = 2'b00,
      FWD_MEM = 2'b01,
      FWD_WB  = 2'b10
   } fwdSel_e;

   typedef enum logic {
      LOAD_IMEM = 1'b0,
      LOAD_DMEM = 1'b1
   } loadTgt_e;

   // rd = rs op rt
   typedef struct packed {
      opcode_e          opcode;
      logic [REG_W-1:0] rs;
      logic [REG_W-1:0] rt;
      logic [REG_W-1:0] rd;
      aluFn_e           fn;
   } rType_t;

   // ST stores register rd; LBI and BEQZ use {rd, imm} as an 8-bit immediate on rs
   typedef struct packed {
      opcode_e          opcode;
      logic [REG_W-1:0] rs;
      logic [REG_W-1:0] rd;
      logic [4:0]       imm;
   } iType_t;

   typedef union packed {
      rType_t rType;
      iType_t iType;
   } instr_u;

   typedef struct packed {
      logic              valid;
      logic [DATA_W-1:0] pc;
      logic [DATA_W-1:0] pcInc;
      instr_u            instr;
   } ifId_t;

   typedef struct packed {
      logic              valid;
      logic [REG_W-1:0]  rs;
      logic [REG_W-1:0]  rt;
      logic [REG_W-1:0]  rd;
      logic [DATA_W-1:0] opA;
      logic [DATA_W-1:0] opB;
      logic [DATA_W-1:0] imm;
      aluFn_e            aluFn;
      logic              useImm;
      logic              memRead;
      logic              memWrite;
      logic              regWrite;
      logic              halt;
   } idEx_t;

   typedef struct packed {
      logic              valid;
      logic [REG_W-1:0]  rd;
      logic [DATA_W-1:0] aluOut;
      logic [DATA_W-1:0] storeData;
      logic              memRead;
      logic              memWrite;
      logic              regWrite;
      logic              halt;
   } exMem_t;

   typedef struct packed {
      logic              valid;
      logic [REG_W-1:0]  rd;
      logic [DATA_W-1:0] aluOut;
      logic [DATA_W-1:0] memData;
      logic              memToReg;
      logic              regWrite;
      logic              halt;
   } memWb_t;

   typedef struct packed {
      logic              strobe;
      loadTgt_e          target;
      logic [DATA_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } loadCmd_t;

   typedef struct packed {
      logic              valid;
      logic [REG_W-1:0]  rd;
      logic [DATA_W-1:0] data;
   } wbObs_t;

   function automatic logic readsRs(instr_u ins);
      case (ins.rType.opcode)
         OP_ALU, OP_ADDI, OP_LD, OP_ST, OP_BEQZ: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic logic readsRt(instr_u ins);
      return ins.rType.opcode inside {OP_ALU, OP_ST};
   endfunction

   // Second source register; the store data sits in the rd slot
   function automatic logic [REG_W-1:0] rtField(instr_u ins);
      return (ins.iType.opcode == OP_ST) ? ins.iType.rd : ins.rType.rt;
   endfunction

   function automatic logic [DATA_W-1:0] wbData(memWb_t m);
      return m.memToReg ? m.memData : m.aluOut;
   endfunction

   function automatic logic [DATA_W-1:0] pickOperand(fwdSel_e sel, logic [DATA_W-1:0] regVal,
                                                     logic [DATA_W-1:0] memVal,
                                                     logic [DATA_W-1:0] wbVal);
      case (sel)
         FWD_MEM: return memVal;
         FWD_WB:  return wbVal;
         default: return regVal;
      endcase
   endfunction

endpackage

`default_nettype wire

// ==== include/proc_cfg.svh ====
// Processor configuration
`ifndef PROC_CFG_SVH
`define PROC_CFG_SVH

// Data and instruction word width
`define PROC_DATA_W 16

`define PROC_IMEM_DEPTH 64
`define PROC_DMEM_DEPTH 64
`define PROC_NUM_REGS 8

`endif
